// ==== source/wb_bus_pkg.sv ====
`default_nettype none

package wb_bus_pkg;

  // Bus widths
  localparam int ADDR_W = 32;               // Byte address
  localparam int DATA_W = 32;               // One word per transfer

  // SRAM geometry
  localparam int MEM_WORDS = 256;           // Depth in words
  localparam int MEM_AW = $clog2(MEM_WORDS); // Word address bits, taken from adr[9:2]

  // Local copy of the master count, keeps arb_pkg free of bus types
  localparam int BUS_MASTERS = 8;

  typedef logic [ADDR_W-1:0] wb_addr_t;
  typedef logic [DATA_W-1:0] wb_data_t;

  // Master side of a Wishbone classic link
  typedef struct packed {
    logic     cyc;                          // Bus cycle, held for ownership
    logic     stb;                          // Transfer strobe
    logic     we;                           // 1 = write
    wb_addr_t adr;                          // Byte address
    wb_data_t dat;                          // Write data
  } wb_req_t;

  // Slave side
  typedef struct packed {
    logic     ack;                          // One cycle per transfer
    wb_data_t dat;                          // Read data, valid with ack
  } wb_rsp_t;

  // One element per master
  typedef wb_req_t [BUS_MASTERS-1:0] req_array_t;
  typedef wb_rsp_t [BUS_MASTERS-1:0] rsp_array_t;

endpackage

`default_nettype wire

// ==== source/arb_pkg.sv ====
`default_nettype none

package arb_pkg;

  // Number of peer masters on the shared bus
  localparam int NUM_MASTERS = 8;
  localparam int IDX_W = 3;                 // Bits to encode a master index

  // One bit per master, at most one set
  typedef logic [NUM_MASTERS-1:0] grant_t;

  // Encoded owner index for the data path
  typedef logic [IDX_W-1:0] master_idx_t;

  // Arbiter states
  typedef enum logic {
    ARB_IDLE  = 1'b0,                       // No owner, next edge may grant
    ARB_OWNED = 1'b1                        // Owner holds the bus while cyc stays high
  } arb_state_e;

endpackage

`default_nettype wire

// ==== source/row_roundrobin.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_roundrobin
  import arb_pkg::*;
(
  input  wire         clk_i,
  input  wire         reset_i,
  input  wire grant_t req_i,                // cyc of every master
  output grant_t      gnt_o,                // Registered one-hot grant
  output master_idx_t gnt_idx_o,            // Encoded grant for the mux
  output logic        round_wrap_o          // Pulse on the first grant of a round
);

  arb_state_e state_q;
  grant_t     mask_q;                       // Masters still due a turn this round
  grant_t     gnt_q;
  logic       wrap_q;

  grant_t     mask_req;                     // Requests still inside the round
  grant_t     mask_pick;                    // Lowest masked requester
  grant_t     raw_pick;                     // Lowest requester overall
  grant_t     gnt_next;
  grant_t     nxt_mask;
  logic       wrap_next;
  logic       owner_hold;

  assign mask_req = req_i & mask_q;

  // Lowest set bit, x & -x
  assign mask_pick = mask_req & (~mask_req + grant_t'(1));
  assign raw_pick  = req_i & (~req_i + grant_t'(1));

  // Fall back to the raw pick once the round is used up
  assign gnt_next = (|mask_req) ? mask_pick : raw_pick;

  // Keep only the bits above the new owner
  assign nxt_mask = ~(gnt_next | (gnt_next - grant_t'(1)));

  // Mask would grow, or nobody has been served since reset
  assign wrap_next = ~(|mask_req) | (&mask_q);

  // Owner keeps the bus while its cyc is high
  assign owner_hold = |(req_i & gnt_q);

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      state_q <= ARB_IDLE;
      mask_q  <= '1;                        // Everybody eligible
      gnt_q   <= '0;
      wrap_q  <= 1'b0;
    end else begin
      wrap_q <= 1'b0;                       // Single-cycle pulse
      case (state_q)
        ARB_IDLE: begin
          if (|req_i) begin
            state_q <= ARB_OWNED;
            gnt_q   <= gnt_next;
            mask_q  <= nxt_mask;            // Mask moves only on a new grant
            wrap_q  <= wrap_next;
          end
        end
        ARB_OWNED: begin
          if (!owner_hold) begin
            state_q <= ARB_IDLE;            // Release, one idle cycle between owners
            gnt_q   <= '0;
          end
        end
        default: begin
          state_q <= ARB_IDLE;
          gnt_q   <= '0;
        end
      endcase
    end
  end

  // One-hot to binary, OR of the grant bits per index bit
  always_comb begin
    gnt_idx_o = '0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (gnt_q[i]) begin
        gnt_idx_o = gnt_idx_o | master_idx_t'(i);
      end
    end
  end

  assign gnt_o        = gnt_q;
  assign round_wrap_o = wrap_q;

endmodule

`default_nettype wire

// ==== source/wb_master_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_master_mux
  import wb_bus_pkg::*;
  import arb_pkg::*;
(
  input  wire req_array_t  wbm_req_i,       // All master requests
  output rsp_array_t       wbm_rsp_o,       // Per-master responses
  input  wire grant_t      gnt_i,           // One-hot owner
  input  wire master_idx_t gnt_idx_i,       // Same owner, encoded
  output wb_req_t          wbs_req_o,       // Toward the SRAM
  input  wire wb_rsp_t     wbs_rsp_i        // From the SRAM
);

  wb_req_t owner_req;                       // Request of the indexed master
  logic    owner_valid;                     // Index actually granted

  // Index defaults to 0 when idle, so qualify with the one-hot grant
  assign owner_req   = wbm_req_i[gnt_idx_i];
  assign owner_valid = gnt_i[gnt_idx_i];

  // Address, data and we pass through, strobes only for a real owner
  always_comb begin
    wbs_req_o     = owner_req;
    wbs_req_o.cyc = owner_req.cyc & owner_valid;
    wbs_req_o.stb = owner_req.stb & owner_valid; // Idle bus shows no strobe
  end

  // Read data to everyone, ack to the owner only
  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      wbm_rsp_o[i].dat = wbs_rsp_i.dat;
      wbm_rsp_o[i].ack = wbs_rsp_i.ack & gnt_i[i];
    end
  end

endmodule

`default_nettype wire

// ==== source/wb_sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_sram_slave
  import wb_bus_pkg::*;
(
  input  wire          clk_i,
  input  wire          reset_i,
  input  wire wb_req_t wbs_req_i,           // Granted master's request
  output wb_rsp_t      wbs_rsp_o            // Registered ack and read data
);

  wb_data_t mem [MEM_WORDS];                // Contents survive reset

  logic [MEM_AW-1:0] word_adr;              // adr[9:2], other bits ignored
  logic              access;                // New transfer this cycle
  logic              ack_q;
  wb_data_t          rdata_q;

  assign word_adr = wbs_req_i.adr[MEM_AW+1:2];

  // Ack low means the strobe has not been answered yet
  assign access = wbs_req_i.cyc & wbs_req_i.stb & ~ack_q;

  // Ack for one cycle, then a gap before the next strobe is taken
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Write commits on the ack edge
  always_ff @(posedge clk_i) begin
    if (access && wbs_req_i.we) begin
      mem[word_adr] <= wbs_req_i.dat;
    end
  end

  // Read data lands together with ack
  always_ff @(posedge clk_i) begin
    if (access && !wbs_req_i.we) begin
      rdata_q <= mem[word_adr];
    end
  end

  assign wbs_rsp_o.ack = ack_q;
  assign wbs_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// ==== source/wb_shared_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_shared_sram
  import wb_bus_pkg::*;
  import arb_pkg::*;
(
  input  wire             clk_i,
  input  wire             reset_i,
  input  wire req_array_t wbm_req_i,        // Eight masters
  output rsp_array_t      wbm_rsp_o,
  output logic            round_wrap_o      // New arbitration round
);

  grant_t      mst_cyc;                     // cyc bits as arbiter requests
  grant_t      gnt;
  master_idx_t gnt_idx;
  wb_req_t     sram_req;
  wb_rsp_t     sram_rsp;

  // Collect cyc of each master
  for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_cyc
    assign mst_cyc[i] = wbm_req_i[i].cyc;
  end

  row_roundrobin u_arb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (mst_cyc),
    .gnt_o        (gnt),
    .gnt_idx_o    (gnt_idx),
    .round_wrap_o (round_wrap_o)
  );

  wb_master_mux u_mux (
    .wbm_req_i (wbm_req_i),
    .wbm_rsp_o (wbm_rsp_o),
    .gnt_i     (gnt),
    .gnt_idx_i (gnt_idx),
    .wbs_req_o (sram_req),
    .wbs_rsp_i (sram_rsp)
  );

  wb_sram_slave u_sram (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wbs_req_i (sram_req),
    .wbs_rsp_o (sram_rsp)
  );

endmodule

`default_nettype wire

// ==== test/tb_wb_shared_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_shared_sram
  import wb_bus_pkg::*;
  import arb_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RAND_BATCHES = 24;
  localparam int MAX_OPS      = 3;                  // Transfers per master in one random batch
  localparam int DIRECTED_XFERS = 2 + 16 + 3 + 10;
  localparam int TOTAL_XFERS  = DIRECTED_XFERS + RAND_BATCHES * NUM_MASTERS * MAX_OPS;
  localparam int TIMEOUT_NS   = (TOTAL_XFERS * 8 + 40) * CLK_PERIOD; // Slack for reset and gaps
  localparam logic [31:0] SEED = 32'h3bbe_ab73;

  // One queued transfer of a master
  typedef struct packed {
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } op_t;

  logic       clk_i;
  logic       reset_i;
  req_array_t wbm_req;
  rsp_array_t wbm_rsp;
  logic       round_wrap;

  op_t      ops [NUM_MASTERS][$];                   // Pending transfers per master
  wb_data_t ref_mem [MEM_WORDS];                    // Reference memory
  logic     ref_valid [MEM_WORDS];                  // Word written at least once
  int       last_owner;                             // Order model, -1 right after reset
  int       active_cnt;                             // Masters still busy in a batch
  int       first_lat [NUM_MASTERS];                // Cycles to first ack
  int       ack_idx [$];                            // Ack log, master index
  logic     ack_wrap [$];                           // Wrap seen in the grant cycle
  logic     wrap_prev;

  wb_shared_sram UUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wbm_req_i    (wbm_req),
    .wbm_rsp_o    (wbm_rsp),
    .round_wrap_o (round_wrap)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // Watchdog, generous per-transfer budget
  initial begin
    #(TIMEOUT_NS);
    report_fail("watchdog expired, the DUT stopped acknowledging transfers");
  end

  // Ack log, one entry per acked transfer
  always @(negedge clk_i) begin : ack_monitor
    logic [NUM_MASTERS-1:0] acks;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      acks[i] = wbm_rsp[i].ack;
    end
    if (!reset_i) begin
      assert ($onehot0(acks))
        else report_fail($sformatf("error: wbm_rsp_o ack vector 0x%h has more than one bit", acks));
      assert (!wrap_prev || acks != '0)
        else report_fail("round_wrap_o pulsed but no transfer was acknowledged next cycle");
      for (int i = 0; i < NUM_MASTERS; i++) begin
        if (acks[i]) begin
          ack_idx.push_back(i);
          ack_wrap.push_back(wrap_prev);            // Grant cycle precedes the first ack
        end
      end
    end
    wrap_prev = round_wrap;
  end

  // Selection rule, next index above last else lowest overall
  function automatic int pick_next(input logic [NUM_MASTERS-1:0] pend, input int last);
    for (int i = last + 1; i < NUM_MASTERS; i++) begin
      if (pend[i]) return i;
    end
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (pend[i]) return i;
    end
    return -1;
  endfunction

  task automatic add_op(input int m, input logic we, input wb_addr_t adr, input wb_data_t dat);
    op_t o;
    o.we  = we;
    o.adr = adr;
    o.dat = dat;
    ops[m].push_back(o);
  endtask

  // Update or compare the reference memory at ack
  task automatic check_response(input int m, input op_t cur);
    logic [MEM_AW-1:0] w;
    w = cur.adr[MEM_AW+1:2];
    if (cur.we) begin
      ref_mem[w]   = cur.dat;
      ref_valid[w] = 1'b1;
    end else if (ref_valid[w]) begin
      assert (wbm_rsp[m].dat == ref_mem[w])
        else report_fail($sformatf("error: wbm_rsp_o[%0d].dat adr 0x%h expected 0x%h got 0x%h",
                                   m, cur.adr, ref_mem[w], wbm_rsp[m].dat));
    end
  endtask

  // One master, all its queued transfers with cyc held
  task automatic run_master(input int m);
    op_t cur;
    int  waits;
    bit  first;
    first = 1'b1;
    while (ops[m].size() > 0) begin
      cur = ops[m].pop_front();
      wbm_req[m].cyc = 1'b1;
      wbm_req[m].stb = 1'b1;
      wbm_req[m].we  = cur.we;
      wbm_req[m].adr = cur.adr;
      wbm_req[m].dat = cur.dat;
      waits = 0;
      do begin
        @(negedge clk_i);
        waits++;
      end while (!wbm_rsp[m].ack);
      if (first) first_lat[m] = waits;
      first = 1'b0;
      check_response(m, cur);
      if (ops[m].size() == 0) begin
        wbm_req[m].cyc = 1'b0;                      // Release ownership
        wbm_req[m].stb = 1'b0;
        wbm_req[m].we  = 1'b0;
      end
    end
    active_cnt--;
  endtask

  // Compare the ack log with the order model
  task automatic check_order(input int n [NUM_MASTERS]);
    logic [NUM_MASTERS-1:0] pend;
    int   total;
    int   pos;
    int   pick;
    logic exp_wrap;
    pend  = '0;
    total = 0;
    pos   = 0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      pend[m] = (n[m] > 0);
      total += n[m];
    end
    assert (ack_idx.size() == total)
      else report_fail($sformatf("error: ack count expected 0x%h got 0x%h", total, ack_idx.size()));
    while (pend != '0) begin
      pick     = pick_next(pend, last_owner);
      exp_wrap = (last_owner < 0) || (pick <= last_owner);
      for (int k = 0; k < n[pick]; k++) begin
        assert (ack_idx[pos] == pick)
          else report_fail($sformatf("error: ack owner expected 0x%h got 0x%h", pick, ack_idx[pos]));
        assert (ack_wrap[pos] == ((k == 0) ? exp_wrap : 1'b0))
          else report_fail($sformatf("error: round_wrap_o for master %0d expected 0x%h got 0x%h",
                                     pick, (k == 0) ? exp_wrap : 1'b0, ack_wrap[pos]));
        pos++;
      end
      pend[pick] = 1'b0;
      last_owner = pick;
    end
  endtask

  // Start every queued master on the same falling edge
  task automatic run_batch();
    int n [NUM_MASTERS];
    ack_idx.delete();
    ack_wrap.delete();
    active_cnt = 0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      n[m] = ops[m].size();
      if (n[m] > 0) active_cnt++;
    end
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (n[m] > 0) begin
        fork
          automatic int mm = m;
          run_master(mm);
        join_none
      end
    end
    wait (active_cnt == 0);
    @(negedge clk_i);                               // Arbiter drops the last owner
    check_order(n);
  endtask

  task automatic check_idle();
    for (int m = 0; m < NUM_MASTERS; m++) begin
      assert (!wbm_rsp[m].ack)
        else report_fail($sformatf("error: wbm_rsp_o[%0d].ack expected 0x0 got 0x%h",
                                   m, wbm_rsp[m].ack));
    end
    assert (!round_wrap)
      else report_fail($sformatf("error: round_wrap_o expected 0x0 got 0x%h", round_wrap));
  endtask

  task automatic reset_test();
    repeat (4) begin
      @(negedge clk_i);
      check_idle();                                 // During reset
    end
    reset_i = 1'b0;
    @(negedge clk_i);
    check_idle();                                   // Just after
  endtask

  // Master 7 alone, so the next round starts at 0
  task automatic lone_master_test();
    add_op(7, 1'b1, 32'h0000_0040, 32'hcafe_0007);
    run_batch();
    assert (first_lat[7] == 2)
      else report_fail($sformatf("error: write ack latency expected 0x2 got 0x%h", first_lat[7]));
    add_op(7, 1'b0, 32'h0000_0040, '0);
    run_batch();
    assert (first_lat[7] == 2)
      else report_fail($sformatf("error: read ack latency expected 0x2 got 0x%h", first_lat[7]));
  endtask

  task automatic all_masters_test();
    for (int m = 0; m < NUM_MASTERS; m++) begin
      add_op(m, 1'b1, wb_addr_t'(32'h100 + m * 4), wb_data_t'(32'ha5a5_0000 + m));
    end
    run_batch();                                    // Order 0 to 7, wrap on master 0
    for (int m = 0; m < NUM_MASTERS; m++) begin
      add_op(m, 1'b0, wb_addr_t'(32'h100 + m * 4), '0);
    end
    run_batch();
  endtask

  task automatic continuation_test();
    add_op(5, 1'b1, 32'h0000_0200, 32'h5555_0005);
    run_batch();
    add_op(2, 1'b1, 32'h0000_0204, 32'h2222_0002);
    add_op(6, 1'b1, 32'h0000_0208, 32'h6666_0006);
    run_batch();
    assert (ack_idx[0] == 6 && ack_idx[1] == 2)
      else report_fail($sformatf("error: ack owners expected 0x6 0x2 got 0x%h 0x%h",
                                 ack_idx[0], ack_idx[1]));
    assert (ack_wrap[1])
      else report_fail($sformatf("error: round_wrap_o with master 2 expected 0x1 got 0x%h",
                                 ack_wrap[1]));
  endtask

  // Master 3 holds cyc for four transfers while master 1 waits
  task automatic ownership_hold_test();
    for (int k = 0; k < 4; k++) begin
      add_op(3, 1'b1, wb_addr_t'(32'h300 + k * 4), wb_data_t'(32'h3c3c_0000 + k));
    end
    add_op(1, 1'b1, 32'h0000_0310, 32'h1111_0001);
    run_batch();
    for (int k = 0; k < 4; k++) begin
      add_op(3, 1'b0, wb_addr_t'(32'h300 + k * 4), '0);
    end
    add_op(1, 1'b0, 32'h0000_0310, '0);
    run_batch();
    for (int k = 0; k < 4; k++) begin
      assert (ack_idx[k] == 3)
        else report_fail($sformatf("error: ack owner expected 0x3 got 0x%h", ack_idx[k]));
    end
    assert (ack_idx[4] == 1)
      else report_fail($sformatf("error: ack owner expected 0x1 got 0x%h", ack_idx[4]));
  endtask

  task automatic random_traffic_test();
    logic [NUM_MASTERS-1:0] sub;
    int nops;
    repeat (RAND_BATCHES) begin
      sub = NUM_MASTERS'($urandom_range(255, 1));
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (sub[m]) begin
          nops = $urandom_range(MAX_OPS, 1);
          for (int k = 0; k < nops; k++) begin
            add_op(m, 1'($urandom), wb_addr_t'($urandom), wb_data_t'($urandom));
          end
        end
      end
      run_batch();
    end
  endtask

  initial begin
    void'($urandom(SEED));
    reset_i    = 1'b1;
    wbm_req    = '0;
    last_owner = -1;
    wrap_prev  = 1'b0;
    active_cnt = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_valid[i] = 1'b0;
    end
    for (int m = 0; m < NUM_MASTERS; m++) begin
      first_lat[m] = 0;
    end
    reset_test();
    lone_master_test();
    all_masters_test();
    continuation_test();
    ownership_hold_test();
    random_traffic_test();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== wb_shared_sram.f ====
source/wb_bus_pkg.sv
source/arb_pkg.sv
source/row_roundrobin.sv
source/wb_master_mux.sv
source/wb_sram_slave.sv
source/wb_shared_sram.sv
test/tb_wb_shared_sram.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only when TEST PASS is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_wb_shared_sram \
  -f wb_shared_sram.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST PASS" &&
echo "simulation passed" ||
{
  echo "simulation failed"
  exit 1
}
